// ==== turfio_config.svh ====
`ifndef TURFIO_CONFIG_SVH
`define TURFIO_CONFIG_SVH

// Ident word, ASCII "TFIO"
`define TIO_IDENT 32'h5446494F

// Firmware date code and version fields
`define TIO_FW_DATE 16'h0000
`define TIO_FW_VERSION {4'd0, 4'd0, 8'd36}
`define TIO_DATEVERSION {`TIO_FW_DATE, `TIO_FW_VERSION}

// Region map, 4 KB per region
`define TIO_REGION_ID 10'd0
// Read value for accesses that hit no region
`define TIO_UNMAPPED_DATA 32'hBADADD00

// Sync period is 2**4 = 16 cycles
`define TIO_SYNC_PERIOD_BITS 4

// Register word offsets in the ID/control region
`define TIO_REG_IDENT 10'd0
`define TIO_REG_VERSION 10'd1
`define TIO_REG_CTRL 10'd2
`define TIO_REG_STATUS 10'd3
`define TIO_REG_OFFSETS 10'd4
`define TIO_REG_COUNT_LO 10'd5
`define TIO_REG_COUNT_HI 10'd6
`define TIO_REG_TRIG 10'd7

`endif

// ==== turfio_pkg.sv ====
package turfio_pkg;

    // Bus widths
    // Byte address, 32-bit words
    typedef logic [21:0] wb_adr_t;
    typedef logic [31:0] wb_dat_t;
    // Word index inside one 4 KB region
    typedef logic [9:0] reg_adr_t;

    // TURF command path
    typedef logic [31:0] cmd_word_t;
    typedef logic [14:0] trig_time_t;

    // Sync and clock alignment
    typedef logic [7:0] offset_t;
    typedef logic [47:0] clk_count_t;

    // Command type field, bits 31:30 of the command word
    typedef enum logic [1:0] {
        cmd_none = 2'd0,
        cmd_sync = 2'd1,
        cmd_pps  = 2'd2,
        cmd_trig = 2'd3
    } cmd_kind_t;

endpackage

// ==== turfio_intercon.sv ====
`timescale 1ns/10ps
`include "turfio_config.svh"

module turfio_intercon (
    input  logic                 wb_clk_i,
    input  logic                 rst_i,
    // Master side
    input  logic                 wb_cyc_i,
    input  logic                 wb_stb_i,
    input  logic                 wb_we_i,
    input  turfio_pkg::wb_adr_t  wb_adr_i,
    input  turfio_pkg::wb_dat_t  wb_dat_i,
    output turfio_pkg::wb_dat_t  wb_dat_o,
    output logic                 wb_ack_o,
    // ID/control slave side
    output logic                 id_stb_o,
    output logic                 id_we_o,
    output turfio_pkg::reg_adr_t id_adr_o,
    output turfio_pkg::wb_dat_t  id_dat_o,
    input  turfio_pkg::wb_dat_t  id_dat_i,
    input  logic                 id_ack_i
);

    ////////////////////////////////////////////////////////////
    // Region decode
    ////////////////////////////////////////////////////////////

    // Region field is address bits 21:12
    logic       id_hit;
    logic       unmap_req;
    logic       unmap_ack;

    assign id_hit    = (wb_adr_i[21:12] == `TIO_REGION_ID);
    assign unmap_req = wb_cyc_i & wb_stb_i & ~id_hit;

    // Strobe only reaches the register block on a hit
    assign id_stb_o = wb_cyc_i & wb_stb_i & id_hit;
    assign id_we_o  = wb_we_i;
    // Word index, bits 11:2
    assign id_adr_o = wb_adr_i[11:2];
    assign id_dat_o = wb_dat_i;

    ////////////////////////////////////////////////////////////
    // Unmapped responder
    ////////////////////////////////////////////////////////////

    // Single-cycle ack, same timing as the slave
    // Writes here go nowhere
    always_ff @(posedge wb_clk_i) begin
        if (rst_i) begin
            unmap_ack <= 1'b0;
        end else begin
            unmap_ack <= unmap_req & ~unmap_ack;
        end
    end

    // Merge responses back to the master
    assign wb_ack_o = id_ack_i | unmap_ack;
    assign wb_dat_o = unmap_ack ? `TIO_UNMAPPED_DATA : id_dat_i;

endmodule

// ==== tio_id_ctrl.sv ====
`timescale 1ns/10ps
`include "turfio_config.svh"

module tio_id_ctrl (
    input  logic                   wb_clk_i,
    input  logic                   rst_i,
    // Region slave port
    input  logic                   wb_stb_i,
    input  logic                   wb_we_i,
    input  turfio_pkg::reg_adr_t   wb_adr_i,
    input  turfio_pkg::wb_dat_t    wb_dat_i,
    output turfio_pkg::wb_dat_t    wb_dat_o,
    output logic                   wb_ack_o,
    // Board status inputs
    input  logic [1:0]             crate_conf_i,
    input  logic                   i2c_rdy_i,
    // Board control outputs
    output logic                   enable_crate_o,
    output logic                   enable_3v3_o,
    // Sync counter control
    output logic                   en_ext_sync_o,
    output turfio_pkg::offset_t    sync_offset_o,
    output turfio_pkg::offset_t    clock_offset_o,
    input  turfio_pkg::clk_count_t count_i,
    // Trigger time from decoder
    input  turfio_pkg::trig_time_t trig_time_i,
    input  logic                   trig_valid_i
);

    // Access accepted this cycle, one per transaction
    logic                   access;
    logic                   wr_en;
    turfio_pkg::wb_dat_t    rd_data;
    // Upper count bits, frozen by a COUNT_LO read
    logic [15:0]            count_hi_q;
    turfio_pkg::trig_time_t trig_time_q;
    logic                   trig_seen_q;

    assign access = wb_stb_i & ~wb_ack_o;
    assign wr_en  = access & wb_we_i;

    ////////////////////////////////////////////////////////////
    // Bus handshake and read path
    ////////////////////////////////////////////////////////////

    always_ff @(posedge wb_clk_i) begin
        if (rst_i) begin
            wb_ack_o <= 1'b0;
        end else begin
            wb_ack_o <= access;
        end
    end

    // Read mux
    always_comb begin
        case (wb_adr_i)
            `TIO_REG_IDENT:    rd_data = `TIO_IDENT;
            `TIO_REG_VERSION:  rd_data = `TIO_DATEVERSION;
            `TIO_REG_CTRL:     rd_data = {29'd0, en_ext_sync_o, enable_3v3_o, enable_crate_o};
            `TIO_REG_STATUS:   rd_data = {29'd0, i2c_rdy_i, crate_conf_i};
            `TIO_REG_OFFSETS:  rd_data = {16'd0, clock_offset_o, sync_offset_o};
            `TIO_REG_COUNT_LO: rd_data = count_i[31:0];
            `TIO_REG_COUNT_HI: rd_data = {16'd0, count_hi_q};
            `TIO_REG_TRIG:     rd_data = {trig_seen_q, 16'd0, trig_time_q};
            default:           rd_data = 32'd0;
        endcase
    end

    // Read data lines up with ack
    always_ff @(posedge wb_clk_i) begin
        if (access) begin
            wb_dat_o <= rd_data;
        end
        // Snapshot top of count with the low word
        if (access && !wb_we_i && wb_adr_i == `TIO_REG_COUNT_LO) begin
            count_hi_q <= count_i[47:32];
        end
    end

    ////////////////////////////////////////////////////////////
    // Control registers
    ////////////////////////////////////////////////////////////

    always_ff @(posedge wb_clk_i) begin
        if (rst_i) begin
            enable_crate_o <= 1'b0;
            enable_3v3_o   <= 1'b0;
            en_ext_sync_o  <= 1'b0;
            sync_offset_o  <= '0;
            clock_offset_o <= '0;
        end else if (wr_en) begin
            // Read-only and unlisted words drop writes
            case (wb_adr_i)
                `TIO_REG_CTRL: begin
                    enable_crate_o <= wb_dat_i[0];
                    enable_3v3_o   <= wb_dat_i[1];
                    en_ext_sync_o  <= wb_dat_i[2];
                end
                `TIO_REG_OFFSETS: begin
                    sync_offset_o  <= wb_dat_i[7:0];
                    clock_offset_o <= wb_dat_i[15:8];
                end
                default: ;
            endcase
        end
    end

    // Last trigger time, bit 31 flags any trigger seen
    always_ff @(posedge wb_clk_i) begin
        if (rst_i) begin
            trig_time_q <= '0;
            trig_seen_q <= 1'b0;
        end else if (trig_valid_i) begin
            trig_time_q <= trig_time_i;
            trig_seen_q <= 1'b1;
        end
    end

endmodule

// ==== pueo_command_decoder.sv ====
`timescale 1ns/10ps

module pueo_command_decoder (
    input  logic                   wb_clk_i,
    input  logic                   rst_i,
    // TURF command word and qualifier
    input  turfio_pkg::cmd_word_t  command_i,
    input  logic                   command_valid_i,
    // One-cycle event pulses
    output logic                   sync_req_o,
    output logic                   pps_o,
    output logic                   trig_valid_o,
    output turfio_pkg::trig_time_t trig_time_o
);

    // Type field lives in the top two bits
    turfio_pkg::cmd_kind_t kind;

    assign kind = turfio_pkg::cmd_kind_t'(command_i[31:30]);

    // Pulses land one cycle after the valid word
    // A new word can arrive every cycle
    always_ff @(posedge wb_clk_i) begin
        if (rst_i) begin
            sync_req_o   <= 1'b0;
            pps_o        <= 1'b0;
            trig_valid_o <= 1'b0;
        end else begin
            sync_req_o   <= command_valid_i && (kind == turfio_pkg::cmd_sync);
            pps_o        <= command_valid_i && (kind == turfio_pkg::cmd_pps);
            trig_valid_o <= command_valid_i && (kind == turfio_pkg::cmd_trig);
        end
    end

    // Trigger time, bits 14:0, qualified by trig_valid_o
    always_ff @(posedge wb_clk_i) begin
        if (command_valid_i && kind == turfio_pkg::cmd_trig) begin
            trig_time_o <= command_i[14:0];
        end
    end

endmodule

// ==== turfio_sync_count.sv ====
`timescale 1ns/10ps
`include "turfio_config.svh"

module turfio_sync_count (
    input  logic                   wb_clk_i,
    input  logic                   rst_i,
    // Sync request from the command decoder
    input  logic                   sync_req_i,
    input  logic                   en_ext_sync_i,
    // Alignment settings
    input  turfio_pkg::offset_t    sync_offset_i,
    input  turfio_pkg::offset_t    clock_offset_i,
    // Free-running count and sync pulse
    output turfio_pkg::clk_count_t count_o,
    output logic                   sync_o
);

    // Position inside the 16-cycle period
    logic [`TIO_SYNC_PERIOD_BITS-1:0] phase_q;
    logic                             realign;

    // External sync only counts when enabled
    assign realign = sync_req_i & en_ext_sync_i;

    ////////////////////////////////////////////////////////////
    // Phase and clock counters
    ////////////////////////////////////////////////////////////

    always_ff @(posedge wb_clk_i) begin
        if (rst_i) begin
            phase_q <= '0;
            count_o <= '0;
        end else if (realign) begin
            // Restart period, count jumps to the offset
            phase_q <= '0;
            count_o <= {40'd0, clock_offset_i};
        end else begin
            // Phase wraps every period
            phase_q <= phase_q + 1'b1;
            count_o <= count_o + 48'd1;
        end
    end

    // Sync lands where phase meets the low offset bits
    assign sync_o = (phase_q == sync_offset_i[`TIO_SYNC_PERIOD_BITS-1:0]);

endmodule

// ==== pueo_turfio.sv ====
`timescale 1ns/10ps

module pueo_turfio (
    input  logic                  wb_clk_i,
    input  logic                  rst_i,
    // Debug master bus
    input  logic                  wb_cyc_i,
    input  logic                  wb_stb_i,
    input  logic                  wb_we_i,
    input  turfio_pkg::wb_adr_t   wb_adr_i,
    input  turfio_pkg::wb_dat_t   wb_dat_i,
    output turfio_pkg::wb_dat_t   wb_dat_o,
    output logic                  wb_ack_o,
    // TURF command path
    input  turfio_pkg::cmd_word_t command_i,
    input  logic                  command_valid_i,
    // Board I/O
    input  logic [1:0]            crate_conf_i,
    input  logic                  i2c_rdy_i,
    output logic                  enable_crate_o,
    output logic                  enable_3v3_o,
    output logic                  sync_o,
    output logic                  pps_o
);

    // Interconnect to ID/control region
    logic                   id_stb;
    logic                   id_we;
    turfio_pkg::reg_adr_t   id_adr;
    turfio_pkg::wb_dat_t    id_dat_wr;
    turfio_pkg::wb_dat_t    id_dat_rd;
    logic                   id_ack;
    // Sync counter control and count
    logic                   en_ext_sync;
    turfio_pkg::offset_t    sync_offset;
    turfio_pkg::offset_t    clock_offset;
    turfio_pkg::clk_count_t sysclk_count;
    // Decoder events
    logic                   sync_req;
    logic                   trig_valid;
    turfio_pkg::trig_time_t trig_time;

    turfio_intercon u_intercon (
        .wb_clk_i (wb_clk_i),
        .rst_i    (rst_i),
        .wb_cyc_i (wb_cyc_i),
        .wb_stb_i (wb_stb_i),
        .wb_we_i  (wb_we_i),
        .wb_adr_i (wb_adr_i),
        .wb_dat_i (wb_dat_i),
        .wb_dat_o (wb_dat_o),
        .wb_ack_o (wb_ack_o),
        .id_stb_o (id_stb),
        .id_we_o  (id_we),
        .id_adr_o (id_adr),
        .id_dat_o (id_dat_wr),
        .id_dat_i (id_dat_rd),
        .id_ack_i (id_ack)
    );

    // Identification and control registers
    tio_id_ctrl u_id_ctrl (
        .wb_clk_i       (wb_clk_i),
        .rst_i          (rst_i),
        .wb_stb_i       (id_stb),
        .wb_we_i        (id_we),
        .wb_adr_i       (id_adr),
        .wb_dat_i       (id_dat_wr),
        .wb_dat_o       (id_dat_rd),
        .wb_ack_o       (id_ack),
        .crate_conf_i   (crate_conf_i),
        .i2c_rdy_i      (i2c_rdy_i),
        .enable_crate_o (enable_crate_o),
        .enable_3v3_o   (enable_3v3_o),
        .en_ext_sync_o  (en_ext_sync),
        .sync_offset_o  (sync_offset),
        .clock_offset_o (clock_offset),
        .count_i        (sysclk_count),
        .trig_time_i    (trig_time),
        .trig_valid_i   (trig_valid)
    );

    pueo_command_decoder u_decoder (
        .wb_clk_i        (wb_clk_i),
        .rst_i           (rst_i),
        .command_i       (command_i),
        .command_valid_i (command_valid_i),
        .sync_req_o      (sync_req),
        .pps_o           (pps_o),
        .trig_valid_o    (trig_valid),
        .trig_time_o     (trig_time)
    );

    // Sync phase and system clock count
    turfio_sync_count u_synccount (
        .wb_clk_i       (wb_clk_i),
        .rst_i          (rst_i),
        .sync_req_i     (sync_req),
        .en_ext_sync_i  (en_ext_sync),
        .sync_offset_i  (sync_offset),
        .clock_offset_i (clock_offset),
        .count_o        (sysclk_count),
        .sync_o         (sync_o)
    );

endmodule

// ==== tb_pueo_turfio_assert.sv ====
`timescale 1ns/10ps
`include "turfio_config.svh"

module tb_pueo_turfio_assert (
    input logic                clk_i,
    input logic                rst_i,
    input logic                wb_cyc_i,
    input logic                wb_stb_i,
    input logic                wb_ack_i,
    input logic                sync_i,
    input logic                sync_req_i,
    input logic                en_ext_sync_i,
    input turfio_pkg::offset_t sync_offset_i
);

    localparam int PB     = `TIO_SYNC_PERIOD_BITS;
    localparam int PERIOD = 1 << PB;

    // Number of failed properties so far
    int            fail_count = 0;

    logic          sync_q;
    logic [PB-1:0] offset_q;
    // Saturating cycle count since the last rise
    logic [PB:0]   since_rise;
    logic          tracking;
    logic          sync_rise;
    logic          disturb;

    assign sync_rise = sync_i & ~sync_q;
    // Realign or new offset moves the pulse
    assign disturb   = (sync_req_i & en_ext_sync_i) | (sync_offset_i[PB-1:0] != offset_q);

    always_ff @(posedge clk_i) begin
        sync_q   <= sync_i;
        offset_q <= sync_offset_i[PB-1:0];
        if (rst_i || disturb) begin
            tracking   <= 1'b0;
            since_rise <= '0;
        end else if (sync_rise) begin
            tracking   <= 1'b1;
            since_rise <= 1;
        end else if (since_rise != '1) begin
            since_rise <= since_rise + 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////
    // Bus handshake
    ////////////////////////////////////////////////////////////

    ack_one_cycle: assert property (@(posedge clk_i) disable iff (rst_i)
        wb_ack_i |=> !wb_ack_i)
        else begin
            fail_count++;
            $error("ack held for more than one cycle");
        end

    ack_after_req: assert property (@(posedge clk_i) disable iff (rst_i)
        wb_ack_i |-> $past(wb_cyc_i && wb_stb_i))
        else begin
            fail_count++;
            $error("ack without cyc and stb in the cycle before");
        end

    ////////////////////////////////////////////////////////////
    // Sync pulse spacing
    ////////////////////////////////////////////////////////////

    sync_spacing: assert property (@(posedge clk_i) disable iff (rst_i)
        (tracking && !disturb && sync_rise) |-> (int'(since_rise) == PERIOD))
        else begin
            fail_count++;
            $error("sync_o rise came early");
        end

    sync_missing: assert property (@(posedge clk_i) disable iff (rst_i)
        (tracking && !disturb) |-> (int'(since_rise) <= PERIOD))
        else begin
            fail_count++;
            $error("sync_o rise missing in a period");
        end

endmodule

bind pueo_turfio tb_pueo_turfio_assert u_assert (
    .clk_i         (wb_clk_i),
    .rst_i         (rst_i),
    .wb_cyc_i      (wb_cyc_i),
    .wb_stb_i      (wb_stb_i),
    .wb_ack_i      (wb_ack_o),
    .sync_i        (sync_o),
    .sync_req_i    (sync_req),
    .en_ext_sync_i (en_ext_sync),
    .sync_offset_i (sync_offset)
);

// ==== tb_pueo_turfio.sv ====
`timescale 1ns/10ps
`include "turfio_config.svh"

module tb_pueo_turfio;

    // Bus wait and whole-run limits
    localparam int ACK_LIMIT   = 16;
    // Far above the directed run of about 250 cycles
    localparam int CYCLE_LIMIT = 4000;
    localparam int SYNC_PERIOD = 1 << `TIO_SYNC_PERIOD_BITS;

    logic                  clk;
    logic                  rst;
    logic                  wb_cyc;
    logic                  wb_stb;
    logic                  wb_we;
    turfio_pkg::wb_adr_t   wb_adr;
    turfio_pkg::wb_dat_t   wb_dat_wr;
    turfio_pkg::wb_dat_t   wb_dat_rd;
    logic                  wb_ack;
    turfio_pkg::cmd_word_t command;
    logic                  command_valid;
    logic [1:0]            crate_conf;
    logic                  i2c_rdy;
    logic                  enable_crate;
    logic                  enable_3v3;
    logic                  sync;
    logic                  pps;

    logic [31:0]           lcg_state;
    int                    cycle_count = 0;

    pueo_turfio dut0 (
        .wb_clk_i        (clk),
        .rst_i           (rst),
        .wb_cyc_i        (wb_cyc),
        .wb_stb_i        (wb_stb),
        .wb_we_i         (wb_we),
        .wb_adr_i        (wb_adr),
        .wb_dat_i        (wb_dat_wr),
        .wb_dat_o        (wb_dat_rd),
        .wb_ack_o        (wb_ack),
        .command_i       (command),
        .command_valid_i (command_valid),
        .crate_conf_i    (crate_conf),
        .i2c_rdy_i       (i2c_rdy),
        .enable_crate_o  (enable_crate),
        .enable_3v3_o    (enable_3v3),
        .sync_o          (sync),
        .pps_o           (pps)
    );

    // 100 ns clock
    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Watchdog on the cycle counter
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == CYCLE_LIMIT) begin
            $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("sim failed");
            $fatal(1, "watchdog expired");
        end
    end

    ////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////

    // Numerical Recipes LCG constants
    function automatic logic [31:0] lcg_step(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // Region in 21:12 and word in 11:2
    function automatic turfio_pkg::wb_adr_t reg_addr(input logic [9:0] region,
                                                     input logic [9:0] word);
        return {region, word, 2'b00};
    endfunction

    function automatic turfio_pkg::cmd_word_t make_command(input turfio_pkg::cmd_kind_t kind,
                                                           input logic [29:0] body);
        return {kind, body};
    endfunction

    task automatic report_failure(input string line);
        $display("%s", line);
        $display("sim failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic expect_word(input turfio_pkg::wb_dat_t got, input turfio_pkg::wb_dat_t exp,
                               input string what);
        assert (got === exp) else begin
            report_failure($sformatf("Mismatch at %0t: %s is %08h, expected %08h",
                                     $time, what, got, exp));
        end
    endtask

    // Wait for ack and release the bus on the next edge
    task automatic complete_cycle(output turfio_pkg::wb_dat_t data);
        int   waited;
        logic acked;
        waited = 0;
        acked  = 1'b0;
        data   = '0;
        while (!acked && waited < ACK_LIMIT) begin
            @(negedge clk);
            waited++;
            if (wb_ack === 1'b1) begin
                acked = 1'b1;
                data  = wb_dat_rd;
            end
        end
        assert (acked) else begin
            report_failure("Error: bus acknowledge never arrived");
        end
        @(posedge clk);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
    endtask

    task automatic wb_write(input turfio_pkg::wb_adr_t adr, input turfio_pkg::wb_dat_t data);
        turfio_pkg::wb_dat_t ignored;
        @(posedge clk);
        wb_cyc    <= 1'b1;
        wb_stb    <= 1'b1;
        wb_we     <= 1'b1;
        wb_adr    <= adr;
        wb_dat_wr <= data;
        complete_cycle(ignored);
    endtask

    task automatic wb_read(input turfio_pkg::wb_adr_t adr, output turfio_pkg::wb_dat_t data);
        @(posedge clk);
        wb_cyc <= 1'b1;
        wb_stb <= 1'b1;
        wb_we  <= 1'b0;
        wb_adr <= adr;
        complete_cycle(data);
    endtask

    task automatic read_expect(input logic [9:0] word, input turfio_pkg::wb_dat_t exp,
                               input string what);
        turfio_pkg::wb_dat_t got;
        wb_read(reg_addr(`TIO_REGION_ID, word), got);
        expect_word(got, exp, what);
    endtask

    // Valid for exactly one cycle
    task automatic send_command(input turfio_pkg::cmd_word_t word);
        @(posedge clk);
        command       <= word;
        command_valid <= 1'b1;
        @(posedge clk);
        command_valid <= 1'b0;
    endtask

    ////////////////////////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////////////////////////

    task automatic ident_readback();
        read_expect(`TIO_REG_IDENT, `TIO_IDENT, "IDENT");
        read_expect(`TIO_REG_VERSION, `TIO_DATEVERSION, "VERSION");
        // Unlisted word
        read_expect(10'd9, 32'd0, "unlisted word 9");
    endtask

    task automatic ctrl_status_readback();
        turfio_pkg::wb_dat_t val;
        int                  i;
        for (i = 0; i < 3; i++) begin
            lcg_state = lcg_step(lcg_state);
            val = lcg_state;
            wb_write(reg_addr(`TIO_REGION_ID, `TIO_REG_CTRL), val);
            read_expect(`TIO_REG_CTRL, val & 32'h7, "CTRL readback");
            expect_word({31'd0, enable_crate}, {31'd0, val[0]}, "enable_crate_o");
            expect_word({31'd0, enable_3v3}, {31'd0, val[1]}, "enable_3v3_o");
            // Sync offset in 7:0 and clock offset in 15:8
            lcg_state = lcg_step(lcg_state);
            val = lcg_state;
            wb_write(reg_addr(`TIO_REGION_ID, `TIO_REG_OFFSETS), val);
            read_expect(`TIO_REG_OFFSETS, val & 32'hFFFF, "OFFSETS readback");
            // Board inputs seen through STATUS
            lcg_state = lcg_step(lcg_state);
            val = lcg_state;
            @(posedge clk);
            crate_conf <= val[1:0];
            i2c_rdy    <= val[2];
            read_expect(`TIO_REG_STATUS, {29'd0, val[2], val[1:0]}, "STATUS");
        end
    endtask

    task automatic unmapped_access();
        turfio_pkg::wb_dat_t ctrl_before;
        turfio_pkg::wb_dat_t off_before;
        turfio_pkg::wb_dat_t got;
        wb_read(reg_addr(`TIO_REGION_ID, `TIO_REG_CTRL), ctrl_before);
        wb_read(reg_addr(`TIO_REGION_ID, `TIO_REG_OFFSETS), off_before);
        wb_read(reg_addr(10'd5, `TIO_REG_IDENT), got);
        expect_word(got, `TIO_UNMAPPED_DATA, "region 5 read");
        // Same word offsets in another region
        // Inverted data so that a leaked write shows
        wb_write(reg_addr(10'd5, `TIO_REG_CTRL), ~ctrl_before);
        wb_write(reg_addr(10'd5, `TIO_REG_OFFSETS), ~off_before);
        read_expect(`TIO_REG_CTRL, ctrl_before, "CTRL after region 5 write");
        read_expect(`TIO_REG_OFFSETS, off_before, "OFFSETS after region 5 write");
    endtask

    task automatic command_events();
        turfio_pkg::trig_time_t t;
        int                     k;
        read_expect(`TIO_REG_TRIG, 32'd0, "TRIG before any trigger");
        // PPS pulse one cycle after the command edge
        @(negedge clk);
        expect_word({31'd0, pps}, 32'd0, "pps_o idle");
        lcg_state = lcg_step(lcg_state);
        send_command(make_command(turfio_pkg::cmd_pps, lcg_state[29:0]));
        @(negedge clk);
        expect_word({31'd0, pps}, 32'd1, "pps_o pulse");
        @(negedge clk);
        expect_word({31'd0, pps}, 32'd0, "pps_o after pulse");
        // Trigger time in 14:0
        lcg_state = lcg_step(lcg_state);
        t = lcg_state[14:0];
        send_command(make_command(turfio_pkg::cmd_trig, lcg_state[29:0]));
        read_expect(`TIO_REG_TRIG, {1'b1, 16'd0, t}, "TRIG after trigger");
        lcg_state = lcg_step(lcg_state);
        send_command(make_command(turfio_pkg::cmd_none, lcg_state[29:0]));
        for (k = 0; k < 3; k++) begin
            @(negedge clk);
            expect_word({31'd0, pps}, 32'd0, "pps_o after none");
        end
        read_expect(`TIO_REG_TRIG, {1'b1, 16'd0, t}, "TRIG after none");
    endtask

    task automatic ext_sync_alignment();
        turfio_pkg::offset_t    clk_off;
        turfio_pkg::wb_dat_t    lo;
        turfio_pkg::wb_dat_t    hi;
        turfio_pkg::clk_count_t count;
        turfio_pkg::clk_count_t bound;
        logic                   exp_sync;
        int                     first_sync;
        int                     t0;
        int                     n;
        lcg_state = lcg_step(lcg_state);
        clk_off = lcg_state[15:8];
        wb_write(reg_addr(`TIO_REGION_ID, `TIO_REG_OFFSETS), {16'd0, clk_off, 8'd5});
        wb_write(reg_addr(`TIO_REGION_ID, `TIO_REG_CTRL), 32'h4);
        send_command(make_command(turfio_pkg::cmd_sync, lcg_state[29:0]));
        // Decoder cycle then phase 0 up to the offset
        first_sync = 1 + 5;
        @(negedge clk);
        t0 = cycle_count;
        for (n = 1; n <= 3 * SYNC_PERIOD; n++) begin
            @(negedge clk);
            exp_sync = (n >= first_sync) && ((n - first_sync) % SYNC_PERIOD == 0);
            expect_word({31'd0, sync}, {31'd0, exp_sync}, "sync_o after enabled sync");
        end
        // Count restarted from the clock offset
        wb_read(reg_addr(`TIO_REGION_ID, `TIO_REG_COUNT_LO), lo);
        wb_read(reg_addr(`TIO_REGION_ID, `TIO_REG_COUNT_HI), hi);
        @(negedge clk);
        count = {hi[15:0], lo};
        bound = {40'd0, clk_off} + 48'(cycle_count - t0);
        assert (count >= {40'd0, clk_off} && count < bound) else begin
            report_failure($sformatf("Mismatch at %0t: count %0d outside %0d to %0d",
                                     $time, count, clk_off, bound));
        end
        // Phase keeps running with sync disabled
        wb_write(reg_addr(`TIO_REGION_ID, `TIO_REG_CTRL), 32'h0);
        send_command(make_command(turfio_pkg::cmd_sync, lcg_state[29:0]));
        for (n = 0; n < 2 * SYNC_PERIOD; n++) begin
            @(negedge clk);
            exp_sync = ((cycle_count - t0 - 1) % SYNC_PERIOD) == 5;
            expect_word({31'd0, sync}, {31'd0, exp_sync}, "sync_o after disabled sync");
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////

    initial begin
        rst           = 1'b1;
        wb_cyc        = 1'b0;
        wb_stb        = 1'b0;
        wb_we         = 1'b0;
        wb_adr        = '0;
        wb_dat_wr     = '0;
        command       = '0;
        command_valid = 1'b0;
        crate_conf    = 2'b00;
        i2c_rdy       = 1'b0;
        lcg_state     = 32'h9319e828;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        ident_readback();
        ctrl_status_readback();
        unmapped_access();
        command_events();
        ext_sync_alignment();
        repeat (4) @(posedge clk);
        // Bound checker tallies its own failed properties
        if (dut0.u_assert.fail_count == 0) begin
            $display("sim passed");
            $finish;
        end else begin
            $display("sim failed");
            $fatal(1, "bound assertions failed");
        end
    end

endmodule

// ==== compile.f ====
+incdir+.
turfio_pkg.sv
turfio_intercon.sv
tio_id_ctrl.sv
pueo_command_decoder.sv
turfio_sync_count.sv
pueo_turfio.sv
tb_pueo_turfio_assert.sv
tb_pueo_turfio.sv

// ==== Makefile ====
# Verilator flow for the TURFIO control core

VERILATOR ?= verilator
TOP       ?= tb_pueo_turfio
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert --timing

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run, and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qx "sim passed" $(LOG); then echo "PASS"; else echo "FAIL, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
